// ==== Makefile ====
# Verilator build and run for the pulse generator testbench

VERILATOR  ?= verilator
TOP        ?= tb_pulse_gen_top
FILE_LIST  ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from a search for the pass line in the captured output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
verilog/pulse_pkg.sv
verilog/pulse_cfg_regs.sv
verilog/zero_cross_detect.sv
verilog/pulse_channel.sv
verilog/pulse_former.sv
verilog/pulse_gen_top.sv
verification/tb_pulse_gen_top.sv

// ==== verification/tb_pulse_gen_top.sv ====
`default_nettype none

module tb_pulse_gen_top;
   import pulse_pkg::*;

   logic                       a_clk;
   logic                       rst_n;
   cfg_bus_t                   cfg;
   logic                       sample_valid;
   logic signed [sample_w-1:0] sample;
   logic                       run;
   logic                       single_shot;
   logic                       out_valid;
   logic signed [sample_w-1:0] out_data;

   integer seed;            // $random state
   int     errors;          // All checks
   int     tests_run;
   int     tests_bad;
   int     err_at;          // Error count when the test began
   int     starts0;         // DUT channel starts seen
   int     starts1;
   int     s0_at;
   int     s1_at;
   int     cyc;             // Cycles since reset release
   int     last_valid_cyc;
   logic   have_valid;
   logic   m_live;          // Model out of reset
   logic signed [sample_w-1:0] hold;

   ////////////////////
   // Reference model state

   logic [15:0]  m_tbl [0:tbl_entries-1]; // Shape table entries
   logic [15:0]  m_dly [0:1];             // Delay per channel
   logic         m_decided;
   logic         m_sign_pos;
   zc_event_t    m_zc;                    // Registered crossing
   int           m_tick_cnt;
   logic         m_shot_q;
   int           m_shot_cnt;
   logic         m_last_ch;
   logic         m_pend_valid;
   logic         m_pend_ch;
   chan_phase_t  m_phase [0:1];
   int           m_idx [0:1];
   int           m_cnt [0:1];
   logic [1:0]   m_done_q;
   logic         m_fin_valid;
   logic         m_fin_ch;
   logic         m_out_valid;
   logic signed [sample_w-1:0] m_out_data;

   pulse_gen_top UUT (
      .a_clk        (a_clk),
      .rst_n        (rst_n),
      .cfg          (cfg),
      .sample_valid (sample_valid),
      .sample       (sample),
      .run          (run),
      .single_shot  (single_shot),
      .out_valid    (out_valid),
      .out_data     (out_data)
   );

   initial a_clk = 1'b0;
   always #5 a_clk = ~a_clk;                      // Period 10

   function automatic int rand_below(input int n);
      return int'(($random(seed) & 32'h7fff_ffff) % n);
   endfunction

   // First segment from 'from' on that takes ticks or num_seg when none is left
   function automatic int next_seg(input int ch, input int from);
      int hit;
      hit = num_seg;
      for (int k = from; k < num_seg; k++)
      begin
         if (hit == num_seg && m_tbl[4*k+ch] != 16'd0) hit = k;
      end
      return hit;
   endfunction

   function automatic logic signed [sample_w-1:0] chan_level(input int ch);
      case (m_phase[ch])
         segment: return m_tbl[4*m_idx[ch]+2+ch];  // Height of segment k
         delay:   return m_tbl[24+ch];             // Pre bias
         done:    return m_tbl[26+ch];             // Post bias
         default: return '0;
      endcase
   endfunction

   task automatic enter_seg(input int ch, input int from);
      int k;
      k = next_seg(ch, from);
      if (k == num_seg)
         m_phase[ch] = done;                       // Program over
      else
      begin
         m_phase[ch] = segment;
         m_idx[ch]   = k;
         m_cnt[ch]   = int'(m_tbl[4*k+ch]);        // Width in ticks
      end
   endtask

   task automatic chan_tick(input int ch, input logic go);
      if (go)
      begin
         if (m_dly[ch] != 16'd0)
         begin
            m_phase[ch] = delay;
            m_cnt[ch]   = int'(m_dly[ch]);
         end
         else
            enter_seg(ch, 0);                      // Straight to the segments
      end
      else if (m_phase[ch] == delay || m_phase[ch] == segment)
      begin
         if (m_cnt[ch] == 1)
            enter_seg(ch, (m_phase[ch] == segment) ? m_idx[ch] + 1 : 0);
         else
            m_cnt[ch]--;
      end
   endtask

   task automatic model_reset();
      for (int i = 0; i < tbl_entries; i++) m_tbl[i] = '0;
      for (int c = 0; c < 2; c++)
      begin
         m_dly[c]   = '0;
         m_phase[c] = idle;
         m_idx[c]   = 0;
         m_cnt[c]   = 0;
      end
      m_decided    = 1'b0;
      m_sign_pos   = 1'b0;
      m_zc         = '0;
      m_tick_cnt   = 0;
      m_shot_q     = 1'b0;
      m_shot_cnt   = 0;
      m_last_ch    = 1'b1;                         // Channel 0 goes first
      m_pend_valid = 1'b0;
      m_pend_ch    = 1'b0;
      m_done_q     = 2'b00;
      m_fin_valid  = 1'b0;
      m_fin_ch     = 1'b0;
      m_out_valid  = 1'b0;
      m_out_data   = '0;
   endtask

   // One clock of the model from the state before the edge
   task automatic model_step();
      logic tick;
      logic shot_rise;
      logic tgt;
      logic free;
      logic accept;
      logic go0;
      logic go1;
      logic signed [sample_w-1:0] mix;
      int   s;
      tick      = m_tick_cnt == tick_div - 1;
      shot_rise = single_shot && !m_shot_q;
      tgt       = !m_zc.rising;                    // Falling asks for channel 1
      free      = m_phase[tgt] == idle || m_phase[tgt] == done;
      accept    = m_zc.strobe && (run || m_shot_cnt > 0) && (tgt != m_last_ch) && free
                  && (!m_pend_valid || tick) && !shot_rise;
      go0       = tick && m_pend_valid && !m_pend_ch;
      go1       = tick && m_pend_valid && m_pend_ch;
      if (m_phase[0] == segment)      mix = chan_level(0);  // Mixer priority
      else if (m_phase[1] == segment) mix = chan_level(1);
      else if (m_phase[0] == delay)   mix = chan_level(0);
      else if (m_phase[1] == delay)   mix = chan_level(1);
      else if (m_fin_valid)           mix = chan_level(int'(m_fin_ch));
      else                            mix = m_out_data;
      if (m_phase[1] == done && !m_done_q[1])
      begin
         m_fin_valid = 1'b1;
         m_fin_ch    = 1'b1;
      end
      else if (m_phase[0] == done && !m_done_q[0])
      begin
         m_fin_valid = 1'b1;
         m_fin_ch    = 1'b0;
      end
      m_done_q = {m_phase[1] == done, m_phase[0] == done};
      if (tick)
      begin
         chan_tick(0, go0);
         chan_tick(1, go1);
         m_out_data = mix;
      end
      m_out_valid = tick;                          // Strobe one cycle after the tick
      m_tick_cnt  = tick ? 0 : m_tick_cnt + 1;
      m_shot_q    = single_shot;
      if (shot_rise)
      begin
         m_shot_cnt = 2;
         m_last_ch  = 1'b1;
      end
      else if (accept)
      begin
         m_last_ch = tgt;
         if (m_shot_cnt > 0) m_shot_cnt--;
      end
      if (accept)
      begin
         m_pend_valid = 1'b1;
         m_pend_ch    = tgt;
      end
      else if (tick)
         m_pend_valid = 1'b0;
      s = sample;                                  // Sign extended
      m_zc.strobe = 1'b0;
      if (sample_valid && (s > zc_hyst || s < -zc_hyst))
      begin
         if (m_decided && ((s > zc_hyst) != m_sign_pos))
         begin
            m_zc.strobe = 1'b1;
            m_zc.rising = s > zc_hyst;
         end
         m_decided  = 1'b1;
         m_sign_pos = s > zc_hyst;
      end
      if (cfg.wr && cfg.addr == delay_addr)        // Writes show after this edge
      begin
         m_dly[0] = cfg.data[31:16];
         m_dly[1] = cfg.data[15:0];
      end
      else if (cfg.wr && cfg.addr == shape_addr)
      begin
         for (int j = 0; j < tbl_entries / 2; j++)
         begin
            m_tbl[2*j]   = cfg.data[32*j+16 +: 16];
            m_tbl[2*j+1] = cfg.data[32*j +: 16];
         end
      end
   endtask

   always @(posedge a_clk)
   begin
      if (!rst_n) model_reset();
      else model_step();
      m_live = rst_n;
   end

   ////////////////////
   // Checks

   task automatic check_sample(input string name, input logic signed [sample_w-1:0] got,
                               input logic signed [sample_w-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h at cycle %0d", name, got, exp, cyc);
         errors++;
      end
   endtask

   task automatic check_strobe(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h at cycle %0d", name, got, exp, cyc);
         errors++;
      end
   endtask

   task automatic check_valid_gap(input int got, input int exp);
      if (got != exp)
      begin
         $display("[FAIL] out_valid gap got %h expected %h", got, exp);
         errors++;
      end
   endtask

   always @(negedge a_clk)
   begin
      if (m_live)
      begin
         cyc++;
         if (UUT.u_former.start0 === 1'b1) starts0++;
         if (UUT.u_former.start1 === 1'b1) starts1++;
         check_strobe("out_valid", out_valid, m_out_valid);
         if (out_valid === 1'b1)
         begin
            if (have_valid) check_valid_gap(cyc - last_valid_cyc, tick_div);
            have_valid     = 1'b1;
            last_valid_cyc = cyc;
            check_sample("out_data", out_data, m_out_data);
         end
      end
      else
         have_valid = 1'b0;
   end

   ////////////////////
   // Stimulus helpers

   task automatic abort_on_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("tests failed");
      $finish;
   endtask

   function automatic logic chan_busy();
      return UUT.u_former.phase0 == delay || UUT.u_former.phase0 == segment
             || UUT.u_former.phase1 == delay || UUT.u_former.phase1 == segment
             || UUT.u_former.pend_valid;
   endfunction

   task automatic wait_idle();
      int   n;
      logic busy;
      n    = 0;
      busy = chan_busy();
      while (busy && n < 3000)
      begin
         @(negedge a_clk);
         n++;
         busy = chan_busy();
      end
      if (busy)
         abort_on_timeout("both channels to go idle");
      else
         repeat (2 * tick_div) @(negedge a_clk);  // Post bias reaches out_data
   endtask

   task automatic wait_first_valid();
      int n;
      n = 0;
      while (out_valid !== 1'b1 && n < 4 * tick_div)
      begin
         @(negedge a_clk);
         n++;
      end
      if (out_valid !== 1'b1) abort_on_timeout("the first out_valid");
   endtask

   task automatic write_cfg(input logic [cfg_addr_w-1:0] addr,
                            input logic [cfg_data_w-1:0] data);
      @(negedge a_clk);
      cfg.wr   = 1'b1;
      cfg.addr = addr;
      cfg.data = data;
      @(negedge a_clk);
      cfg.wr   = 1'b0;
   endtask

   // Widths 0..20 and delays 0..15 with free heights and biases
   task automatic load_random_config();
      logic [cfg_data_w-1:0] data;
      logic [15:0]           e;
      data = '0;
      for (int i = 0; i < tbl_entries; i++)
      begin
         if (i < 4 * num_seg && (i % 4) < 2) e = 16'(rand_below(21));
         else e = 16'($random(seed));
         if (i % 2 == 0) data[32*(i/2)+16 +: 16] = e;  // Even entry high half
         else data[32*(i/2) +: 16] = e;
      end
      write_cfg(shape_addr, data);
      write_cfg(delay_addr, {480'd0, 16'(rand_below(16)), 16'(rand_below(16))});
   endtask

   // Square-ish reference with quiet keeping every sample inside the dead band
   task automatic drive_stream(input int cycles, input logic quiet);
      int   left;
      logic pos;
      left = 0;
      pos  = rand_below(2) == 1;
      for (int c = 0; c < cycles; c++)
      begin
         @(negedge a_clk);
         if (left == 0)
         begin
            pos  = !pos;
            left = 10 + rand_below(190);
         end
         left--;
         sample_valid = rand_below(4) != 0;
         if (quiet) sample = 16'(rand_below(2 * zc_hyst + 1) - zc_hyst);
         else if (pos) sample = 16'(zc_hyst + 1 + rand_below(30000));
         else sample = 16'(-(zc_hyst + 1 + rand_below(30000)));
      end
      @(negedge a_clk);
      sample_valid = 1'b0;
   endtask

   task automatic begin_test();
      @(posedge a_clk);
      err_at = errors;
      s0_at  = starts0;
      s1_at  = starts1;
   endtask

   task automatic end_test(input string name, input logic count_starts,
                           input int exp0, input int exp1);
      int n;
      @(posedge a_clk);
      if (count_starts && (starts0 - s0_at != exp0 || starts1 - s1_at != exp1))
      begin
         $display("%s: channels started %0d and %0d times, expected %0d and %0d",
                  name, starts0 - s0_at, starts1 - s1_at, exp0, exp1);
         errors++;
      end
      n = errors - err_at;
      tests_run++;
      if (n != 0) tests_bad++;
      if (n == 0) $display("test %0d %s: ok", tests_run, name);
      else $display("test %0d %s: %0d errors", tests_run, name, n);
   endtask

   ////////////////////
   // Test sequence

   initial
   begin
      seed         = 30957;
      errors       = 0;
      tests_run    = 0;
      tests_bad    = 0;
      starts0      = 0;
      starts1      = 0;
      cyc          = 0;
      have_valid   = 1'b0;
      m_live       = 1'b0;
      rst_n        = 1'b0;
      cfg          = '0;
      sample_valid = 1'b0;
      sample       = '0;
      run          = 1'b0;
      single_shot  = 1'b0;
      repeat (10) @(negedge a_clk);
      rst_n = 1'b1;

      begin_test();                                // Idle output after reset
      wait_first_valid();
      repeat (40) @(negedge a_clk);
      check_sample("out_data", out_data, '0);
      end_test("after reset", 1'b1, 0, 0);

      begin_test();                                // Free running with alternation
      load_random_config();
      @(negedge a_clk);
      run = 1'b1;
      drive_stream(2000 * tick_div, 1'b0);
      end_test("continuous run", 1'b0, 0, 0);

      @(negedge a_clk);
      run = 1'b0;
      wait_idle();
      begin_test();                                // Crossings ignored
      @(negedge a_clk);
      hold = m_out_data;
      drive_stream(3000, 1'b0);
      check_sample("out_data", out_data, hold);
      end_test("run low", 1'b1, 0, 0);

      begin_test();                                // One program per channel
      @(negedge a_clk);
      single_shot = 1'b1;
      repeat (2) @(negedge a_clk);
      single_shot = 1'b0;
      drive_stream(4000, 1'b0);
      end_test("single shot", 1'b1, 1, 1);

      wait_idle();
      begin_test();                                // Dead band only
      @(negedge a_clk);
      run = 1'b1;
      drive_stream(3000, 1'b1);
      @(negedge a_clk);
      run = 1'b0;
      end_test("hysteresis", 1'b1, 0, 0);

      wait_idle();
      begin_test();                                // New shapes between bursts
      load_random_config();
      @(negedge a_clk);
      run = 1'b1;
      drive_stream(3000, 1'b0);
      @(negedge a_clk);
      run = 1'b0;
      if (starts0 == s0_at)
      begin
         $display("No channel 0 pulse ran after the config rewrite");
         errors++;
      end
      end_test("config rewrite", 1'b0, 0, 0);

      $display("tests run %0d, with errors %0d, errors %0d", tests_run, tests_bad, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/pulse_cfg_regs.sv ====
`default_nettype none

module pulse_cfg_regs (
   input  wire                       a_clk,
   input  wire                       rst_n,
   input  wire pulse_pkg::cfg_bus_t  cfg,
   output pulse_pkg::channel_shape_t shape0,
   output pulse_pkg::channel_shape_t shape1
);
   import pulse_pkg::*;

   logic [31:0] delay_word;             // Ch0 high half, ch1 low half
   logic [15:0] tbl [0:tbl_entries-1];  // Shape table, 16 bit entries

   ////////////////////
   // Write decode

   always_ff @(posedge a_clk)
   begin
      if (!rst_n)
      begin
         delay_word <= '0;
         for (int i = 0; i < tbl_entries; i++)
         begin
            tbl[i] <= '0;
         end
      end
      else if (cfg.wr)
      begin
         case (cfg.addr)
            delay_addr:
            begin
               delay_word <= cfg.data[31:0];               // Both delays in word 0
            end
            shape_addr:
            begin
               for (int j = 0; j < tbl_entries / 2; j++)
               begin
                  tbl[2*j]   <= cfg.data[32*j+16 +: 16];   // Even entry in high half
                  tbl[2*j+1] <= cfg.data[32*j    +: 16];   // Odd entry in low half
               end
            end
            default:
            begin
            end                                            // Unknown address ignored
         endcase
      end
   end

   ////////////////////
   // Table to channel shapes

   always_comb
   begin
      shape0.delay = delay_word[31:16];
      shape1.delay = delay_word[15:0];
      for (int k = 0; k < num_seg; k++)
      begin
         shape0.seg[k].width  = tbl[4*k];                  // Widths interleave ch0 and ch1
         shape1.seg[k].width  = tbl[4*k+1];
         shape0.seg[k].height = tbl[4*k+2];                // Heights follow the widths
         shape1.seg[k].height = tbl[4*k+3];
      end
      shape0.bias_pre  = tbl[4*num_seg];                   // Bias words after the segments
      shape1.bias_pre  = tbl[4*num_seg+1];
      shape0.bias_post = tbl[4*num_seg+2];
      shape1.bias_post = tbl[4*num_seg+3];
   end

   // A write must select a real address or the tables go undefined
   a_addr_known: assert property (@(posedge a_clk) disable iff (!rst_n)
      cfg.wr |-> !$isunknown(cfg.addr));

endmodule

`default_nettype wire

// ==== verilog/pulse_channel.sv ====
`default_nettype none

module pulse_channel (
   input  wire                                   a_clk,
   input  wire                                   rst_n,
   input  wire                                   tick,
   input  wire                                   start,
   input  wire pulse_pkg::channel_shape_t        shape,
   output pulse_pkg::chan_phase_t                phase,
   output logic signed [pulse_pkg::sample_w-1:0] level
);
   import pulse_pkg::*;

   logic [2:0]  seg_idx;   // Current segment
   logic [15:0] cnt;       // Ticks left in delay or segment
   logic [3:0]  ent_from;  // Where the segment search begins
   logic [3:0]  ent_hit;   // First nonzero segment found
   logic        ent_none;  // No segment left
   logic        adv;       // Leave delay or segment this tick

   // First segment at or after from with a nonzero width, num_seg if none
   function automatic logic [3:0] find_seg(input logic [3:0] from,
                                           input channel_shape_t shp);
      logic [3:0] hit;
      hit = 4'(num_seg);
      for (int k = num_seg - 1; k >= 0; k--)
      begin
         if ((4'(k) >= from) && (shp.seg[k].width != '0))
         begin
            hit = 4'(k);
         end
      end
      return hit;
   endfunction

   assign ent_from = (phase == segment && !start) ? {1'b0, seg_idx} + 4'd1 : 4'd0;
   assign ent_hit  = find_seg(ent_from, shape);
   assign ent_none = ent_hit == 4'(num_seg);
   assign adv      = start ? (shape.delay == '0)
                           : ((phase == delay || phase == segment) && cnt == 16'd1);

   ////////////////////
   // Sequencer

   always_ff @(posedge a_clk)
   begin
      if (!rst_n)
      begin
         phase   <= idle;
         seg_idx <= '0;
         cnt     <= '0;
      end
      else if (tick)
      begin
         if (start && shape.delay != '0)
         begin
            phase <= delay;                          // Delay latched at start
            cnt   <= shape.delay;
         end
         else if (adv)
         begin
            if (ent_none)
            begin
               phase <= done;                        // Past segment 5
            end
            else
            begin
               phase   <= segment;                   // Zero widths skipped here
               seg_idx <= ent_hit[2:0];
               cnt     <= shape.seg[ent_hit[2:0]].width;
            end
         end
         else if (phase == delay || phase == segment)
         begin
            cnt <= cnt - 16'd1;
         end
      end
   end

   ////////////////////
   // Level per phase

   always_comb
   begin
      case (phase)
         segment: level = shape.seg[seg_idx].height;
         delay:   level = shape.bias_pre;
         done:    level = shape.bias_post;
         default: level = '0;                        // Idle shows nothing
      endcase
   end

   a_seg_range: assert property (@(posedge a_clk) disable iff (!rst_n)
      seg_idx <= 3'(num_seg - 1));

endmodule

`default_nettype wire

// ==== verilog/pulse_former.sv ====
`default_nettype none

module pulse_former (
   input  wire                                   a_clk,
   input  wire                                   rst_n,
   input  wire                                   run,
   input  wire                                   single_shot,
   input  wire pulse_pkg::zc_event_t             zc,
   input  wire pulse_pkg::channel_shape_t        shape0,
   input  wire pulse_pkg::channel_shape_t        shape1,
   output logic                                  out_valid,
   output logic signed [pulse_pkg::sample_w-1:0] out_data
);
   import pulse_pkg::*;

   logic [tick_w-1:0] tick_cnt;      // Decimation counter
   logic              tick;          // Last clock of the tick period
   logic              shot_q;        // single_shot delayed
   logic              shot_rise;     // Arm edge
   logic [1:0]        shot_cnt;      // Starts left in single shot
   logic              last_ch;       // Channel of the last accepted start
   logic              pend_valid;    // Start waiting for the tick
   logic              pend_ch;
   logic              tgt_ch;        // Channel the crossing asks for
   logic              tgt_free;
   logic              accept;
   logic              start0;
   logic              start1;
   chan_phase_t       phase0;
   chan_phase_t       phase1;
   logic signed [sample_w-1:0] level0;
   logic signed [sample_w-1:0] level1;
   logic signed [sample_w-1:0] mix;
   logic [1:0]        done_q;        // Done flags one cycle back
   logic              fin_valid;     // Some channel has finished
   logic              fin_ch;        // Most recent one

   assign tick      = tick_cnt == tick_w'(tick_div - 1);
   assign shot_rise = single_shot && !shot_q;
   assign tgt_ch    = !zc.rising;    // Rising drives ch0, falling ch1
   assign tgt_free  = tgt_ch ? (phase1 == idle || phase1 == done)
                             : (phase0 == idle || phase0 == done);
   assign accept    = zc.strobe && (run || shot_cnt != 2'd0) && (tgt_ch != last_ch)
                      && tgt_free && (!pend_valid || tick) && !shot_rise;
   assign start0    = tick && pend_valid && !pend_ch;
   assign start1    = tick && pend_valid && pend_ch;

   ////////////////////
   // Tick, arming and pending start

   always_ff @(posedge a_clk)
   begin
      if (!rst_n)
      begin
         tick_cnt   <= '0;
         shot_q     <= 1'b0;
         shot_cnt   <= 2'd0;
         last_ch    <= 1'b1;                          // Channel 0 goes first
         pend_valid <= 1'b0;
         pend_ch    <= 1'b0;
      end
      else
      begin
         tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
         shot_q   <= single_shot;
         if (shot_rise)
         begin
            shot_cnt <= 2'd2;                         // One program per channel
            last_ch  <= 1'b1;
         end
         else if (accept)
         begin
            last_ch <= tgt_ch;
            if (shot_cnt != 2'd0)
            begin
               shot_cnt <= shot_cnt - 2'd1;
            end
         end
         if (accept)
         begin
            pend_valid <= 1'b1;
            pend_ch    <= tgt_ch;
         end
         else if (tick)
         begin
            pend_valid <= 1'b0;                       // Consumed by the channel
         end
      end
   end

   pulse_channel chan0 (
      .a_clk (a_clk),
      .rst_n (rst_n),
      .tick  (tick),
      .start (start0),
      .shape (shape0),
      .phase (phase0),
      .level (level0)
   );

   pulse_channel chan1 (
      .a_clk (a_clk),
      .rst_n (rst_n),
      .tick  (tick),
      .start (start1),
      .shape (shape1),
      .phase (phase1),
      .level (level1)
   );

   ////////////////////
   // Mixer and output

   always_comb
   begin
      if (phase0 == segment)           mix = level0;  // Segments win, ch0 first
      else if (phase1 == segment)      mix = level1;
      else if (phase0 == delay)        mix = level0;  // Then pre bias
      else if (phase1 == delay)        mix = level1;
      else if (fin_valid)              mix = fin_ch ? level1 : level0; // Post bias
      else                             mix = out_data;
   end

   always_ff @(posedge a_clk)
   begin
      if (!rst_n)
      begin
         done_q    <= 2'b00;
         fin_valid <= 1'b0;
         fin_ch    <= 1'b0;
         out_valid <= 1'b0;
         out_data  <= '0;
      end
      else
      begin
         done_q <= {phase1 == done, phase0 == done};
         if (phase1 == done && !done_q[1])
         begin
            fin_valid <= 1'b1;
            fin_ch    <= 1'b1;
         end
         else if (phase0 == done && !done_q[0])
         begin
            fin_valid <= 1'b1;
            fin_ch    <= 1'b0;
         end
         out_valid <= tick;                           // Strobe the cycle after tick
         if (tick)
         begin
            out_data <= mix;
         end
      end
   end

   a_valid_spacing: assert property (@(posedge a_clk) disable iff (!rst_n)
      out_valid |=> !out_valid [*tick_div-1] ##1 out_valid);

endmodule

`default_nettype wire

// ==== verilog/pulse_gen_top.sv ====
`default_nettype none

module pulse_gen_top (
   input  wire                                   a_clk,
   input  wire                                   rst_n,
   input  wire pulse_pkg::cfg_bus_t              cfg,
   input  wire                                   sample_valid,
   input  wire signed [pulse_pkg::sample_w-1:0]  sample,
   input  wire                                   run,
   input  wire                                   single_shot,
   output logic                                  out_valid,
   output logic signed [pulse_pkg::sample_w-1:0] out_data
);
   import pulse_pkg::*;

   channel_shape_t shape0;   // Channel 0 program
   channel_shape_t shape1;   // Channel 1 program
   zc_event_t      zc;       // Crossing events

   ////////////////////
   // Blocks

   pulse_cfg_regs u_cfg (
      .a_clk  (a_clk),
      .rst_n  (rst_n),
      .cfg    (cfg),
      .shape0 (shape0),
      .shape1 (shape1)
   );

   zero_cross_detect u_zc (
      .a_clk        (a_clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .zc           (zc)
   );

   pulse_former u_former (
      .a_clk       (a_clk),
      .rst_n       (rst_n),
      .run         (run),
      .single_shot (single_shot),
      .zc          (zc),
      .shape0      (shape0),
      .shape1      (shape1),
      .out_valid   (out_valid),
      .out_data    (out_data)
   );

endmodule

`default_nettype wire

// ==== verilog/pulse_pkg.sv ====
`default_nettype none

package pulse_pkg;

   ////////////////////
   // Widths and addresses

   localparam int sample_w   = 16;          // Reference and output samples
   localparam int cfg_data_w = 512;         // Config data word
   localparam int cfg_addr_w = 32;          // Config address

   localparam logic [cfg_addr_w-1:0] delay_addr = 32'd20010; // Delay word
   localparam logic [cfg_addr_w-1:0] shape_addr = 32'd20011; // Shape table

   ////////////////////
   // Sequencing constants

   localparam int num_seg     = 6;              // Segments per channel
   localparam int tbl_entries = 4 * num_seg + 4; // Widths, heights and four bias words
   localparam int tick_div    = 4;              // Clocks per output sample
   localparam int tick_w      = $clog2(tick_div); // Tick counter width
   localparam int zc_hyst     = 256;            // Detector dead band

   ////////////////////
   // Bus and shape types

   typedef struct packed {
      logic                  wr;   // Single cycle write strobe
      logic [cfg_addr_w-1:0] addr; // Register select
      logic [cfg_data_w-1:0] data; // Write payload
   } cfg_bus_t;

   typedef struct packed {
      logic [15:0]                width;  // Ticks, zero skips the segment
      logic signed [sample_w-1:0] height; // Output level
   } segment_t;

   typedef struct packed {
      logic [15:0]                     delay;     // Ticks from start to first segment
      logic signed [sample_w-1:0]      bias_pre;  // Level during delay
      logic signed [sample_w-1:0]      bias_post; // Level once finished
      segment_t [num_seg-1:0]          seg;       // Width and height pairs
   } channel_shape_t;

   typedef struct packed {
      logic strobe; // One cycle per sign change
      logic rising; // Negative to positive
   } zc_event_t;

   typedef enum logic [1:0] {
      idle    = 2'd0, // Never started
      delay   = 2'd1, // Counting down the delay
      segment = 2'd2, // Walking the segments
      done    = 2'd3  // Program finished
   } chan_phase_t;

endpackage

`default_nettype wire

// ==== verilog/zero_cross_detect.sv ====
`default_nettype none

module zero_cross_detect (
   input  wire                                  a_clk,
   input  wire                                  rst_n,
   input  wire                                  sample_valid,
   input  wire signed [pulse_pkg::sample_w-1:0] sample,
   output pulse_pkg::zc_event_t                 zc
);
   import pulse_pkg::*;

   logic decided;  // A sign has been seen since reset
   logic sign_pos; // Last decided sign
   logic above;    // Clearly positive
   logic below;    // Clearly negative

   assign above = sample > zc_hyst;       // Signed compare
   assign below = sample < -zc_hyst;

   ////////////////////
   // Sign tracking with hysteresis

   always_ff @(posedge a_clk)
   begin
      if (!rst_n)
      begin
         decided  <= 1'b0;
         sign_pos <= 1'b0;
         zc       <= '0;
      end
      else
      begin
         zc.strobe <= 1'b0;                          // Strobe lasts one cycle
         if (sample_valid && (above || below))
         begin
            decided  <= 1'b1;                        // First sign sets state silently
            sign_pos <= above;
            if (decided && (above != sign_pos))
            begin
               zc.strobe <= 1'b1;                    // Sign flipped
               zc.rising <= above;                   // Direction of the flip
            end
         end
      end
   end

   // Crossings only come from accepted samples, one cycle late
   a_strobe_after_valid: assert property (@(posedge a_clk) disable iff (!rst_n)
      zc.strobe |-> $past(sample_valid));

endmodule

`default_nettype wire
